// ==== rtl/ccu_cfg.svh ====
`ifndef CCU_CFG_SVH
`define CCU_CFG_SVH

// Address widths of the data, grid and scale memories
`define CCU_DATA_ADDR     16
`define CCU_GRID_ADDR     16
`define CCU_SCALE_ADDR    16
`define CCU_PCKT_WIDTH    32

// Result channels per iteration and batch lanes
`define CCU_RSLT_CHANNELS 4
`define CCU_BATCH_SIZE    4
`define CCU_NUM_PERIPH    4

// Host register port
`define CCU_REG_ADDR_W    4
`define CCU_REG_CTRL      0
`define CCU_REG_INTR      1
`define CCU_REG_DATA      2
`define CCU_REG_GRID      3
`define CCU_REG_SCALE     4
`define CCU_REG_RSLT      5
`define CCU_REG_PCKT      6
`define CCU_REG_BTCH      7
`define CCU_REG_LOADED    8
`define CCU_REG_STATUS    9
`define CCU_REG_EXPORTED  10
`define CCU_REG_ITER      11

`endif

// ==== rtl/ccu_pkg.sv ====
`include "ccu_cfg.svh"

package ccu_pkg;

  // Host register port
  typedef logic [31:0]                    reg_word_t;
  typedef logic [`CCU_REG_ADDR_W-1:0]     reg_addr_t;

  // Sizes carry one extra bit so that a full memory fits
  typedef logic [`CCU_DATA_ADDR:0]        data_size_t;
  typedef logic [`CCU_GRID_ADDR:0]        grid_size_t;
  typedef logic [`CCU_SCALE_ADDR:0]       scle_size_t;
  typedef logic [`CCU_PCKT_WIDTH-1:0]     pckt_size_t;

  // Per-iteration lane masks
  typedef logic [`CCU_RSLT_CHANNELS-1:0]  chan_mask_t;
  typedef logic [`CCU_BATCH_SIZE-1:0]     batch_mask_t;
  typedef logic [7:0]                     btch_count_t;

  // Sequencer states
  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_oper,
    st_done,
    st_fault,
    st_halt
  } ccu_state_t;

endpackage

// ==== rtl/ccu_ctrl_if.sv ====
// Parameters, commands and status shared by the three control blocks
interface ccu_ctrl_if;
  import ccu_pkg::*;

  data_size_t  data_size;
  grid_size_t  grid_size;
  scle_size_t  scle_size;
  pckt_size_t  pckt_size;
  reg_word_t   rslt_size;
  btch_count_t btch_size;
  logic        params_valid;
  logic        start_req;
  logic        done_flag;
  logic        soft_cmd;
  logic        abort_cmd;
  logic        error_cmd;
  logic        clear_start;
  logic        set_done;
  logic        busy;
  logic        error;
  logic        locked;
  reg_word_t   results_exported;
  reg_word_t   iter_count;

  modport regs (
    output data_size, grid_size, scle_size, pckt_size, rslt_size, btch_size,
    output params_valid, start_req, done_flag, soft_cmd, abort_cmd, error_cmd,
    input  clear_start, set_done, busy, error, locked, results_exported, iter_count
  );

  modport seq (
    input  data_size, grid_size, scle_size, pckt_size,
    input  params_valid, start_req, done_flag, soft_cmd, abort_cmd, error_cmd,
    output clear_start, set_done, busy, error, locked
  );

  modport track (
    input  rslt_size, btch_size,
    output results_exported, iter_count
  );

endinterface

// Iteration strobes from the sequencer to the result tracker
interface ccu_iter_if;
  logic load;
  logic advance;
  logic clear;
  logic last;

  modport seq (output load, advance, clear, input last);
  modport track (input load, advance, clear, output last);

endinterface

// ==== rtl/ccu_register_file.sv ====
`include "ccu_cfg.svh"

module ccu_register_file (
  input  logic               fsm_clk,
  input  logic               fsm_rst,
  input  logic               reg_wr,
  input  logic               reg_rd,
  input  ccu_pkg::reg_addr_t reg_addr,
  input  ccu_pkg::reg_word_t reg_wdata,
  output ccu_pkg::reg_word_t reg_rdata,
  ccu_ctrl_if.regs           ctrl
);
  import ccu_pkg::*;

  // Largest size each memory can hold
  localparam reg_word_t max_data = reg_word_t'(1) << `CCU_DATA_ADDR;
  localparam reg_word_t max_grid = reg_word_t'(1) << `CCU_GRID_ADDR;
  localparam reg_word_t max_scle = reg_word_t'(1) << `CCU_SCALE_ADDR;

  logic        start_r;
  logic        done_r;
  reg_word_t   data_size_r;
  reg_word_t   grid_size_r;
  reg_word_t   scle_size_r;
  reg_word_t   rslt_size_r;
  reg_word_t   pckt_size_r;
  btch_count_t btch_size_r;
  logic [3:0]  loaded_r;
  logic        intr_wr;
  logic        status_idle;
  reg_word_t   rd_mux;

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      start_r     <= 1'b0;
      done_r      <= 1'b0;
      data_size_r <= '0;
      grid_size_r <= '0;
      scle_size_r <= '0;
      rslt_size_r <= '0;
      pckt_size_r <= '0;
      btch_size_r <= '0;
      loaded_r    <= '0;
    end else begin
      if (reg_wr) begin
        case (reg_addr)
          `CCU_REG_CTRL: begin
            start_r <= reg_wdata[0];
            // Host can only clear done
            done_r  <= done_r & reg_wdata[1];
          end
          `CCU_REG_DATA:   data_size_r <= reg_wdata;
          `CCU_REG_GRID:   grid_size_r <= reg_wdata;
          `CCU_REG_SCALE:  scle_size_r <= reg_wdata;
          `CCU_REG_RSLT:   rslt_size_r <= reg_wdata;
          `CCU_REG_PCKT:   pckt_size_r <= reg_wdata;
          `CCU_REG_BTCH:   btch_size_r <= reg_wdata[7:0];
          `CCU_REG_LOADED: loaded_r    <= reg_wdata[3:0];
          default: begin
          end
        endcase
      end
      // Sequencer strobes win over a host write in the same cycle
      if (ctrl.clear_start) start_r <= 1'b0;
      if (ctrl.set_done) done_r <= 1'b1;
    end
  end

  // Interrupt register bits are pulses, nothing is stored
  assign intr_wr        = reg_wr && (reg_addr == reg_addr_t'(`CCU_REG_INTR));
  assign ctrl.soft_cmd  = intr_wr & reg_wdata[0];
  assign ctrl.abort_cmd = intr_wr & reg_wdata[1];
  assign ctrl.error_cmd = intr_wr & reg_wdata[2];

  assign ctrl.start_req = start_r;
  assign ctrl.done_flag = done_r;
  assign ctrl.data_size = data_size_r[`CCU_DATA_ADDR:0];
  assign ctrl.grid_size = grid_size_r[`CCU_GRID_ADDR:0];
  assign ctrl.scle_size = scle_size_r[`CCU_SCALE_ADDR:0];
  assign ctrl.pckt_size = pckt_size_r[`CCU_PCKT_WIDTH-1:0];
  assign ctrl.rslt_size = rslt_size_r;
  assign ctrl.btch_size = btch_size_r;

  // All inputs loaded, every size nonzero and within range
  assign ctrl.params_valid = (&loaded_r)
      && (data_size_r != '0) && (data_size_r <= max_data)
      && (grid_size_r != '0) && (grid_size_r <= max_grid)
      && (scle_size_r != '0) && (scle_size_r <= max_scle)
      && (rslt_size_r != '0) && (pckt_size_r != '0)
      && (btch_size_r != '0) && (btch_size_r <= btch_count_t'(`CCU_BATCH_SIZE));

  assign status_idle = ~(ctrl.busy | ctrl.error | ctrl.locked);

  always_comb begin
    rd_mux = '0;
    case (reg_addr)
      `CCU_REG_CTRL:     rd_mux[1:0] = {done_r, start_r};
      `CCU_REG_DATA:     rd_mux = data_size_r;
      `CCU_REG_GRID:     rd_mux = grid_size_r;
      `CCU_REG_SCALE:    rd_mux = scle_size_r;
      `CCU_REG_RSLT:     rd_mux = rslt_size_r;
      `CCU_REG_PCKT:     rd_mux = pckt_size_r;
      `CCU_REG_BTCH:     rd_mux[7:0] = btch_size_r;
      `CCU_REG_LOADED:   rd_mux[3:0] = loaded_r;
      `CCU_REG_STATUS: begin
        rd_mux[4:0] = {ctrl.params_valid, ctrl.locked, ctrl.error, ctrl.busy, status_idle};
      end
      `CCU_REG_EXPORTED: rd_mux = ctrl.results_exported;
      `CCU_REG_ITER:     rd_mux = ctrl.iter_count;
      default:           rd_mux = '0;
    endcase
  end

  // Read data lands one cycle after the strobe and holds
  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

// ==== rtl/ccu_result_tracker.sv ====
`include "ccu_cfg.svh"

module ccu_result_tracker (
  input  logic                 fsm_clk,
  input  logic                 fsm_rst,
  ccu_ctrl_if.track            ctrl,
  ccu_iter_if.track            iter,
  output ccu_pkg::chan_mask_t  use_channels,
  output ccu_pkg::batch_mask_t use_batch
);
  import ccu_pkg::*;

  reg_word_t   remaining;
  reg_word_t   cur_size;
  reg_word_t   exported;
  reg_word_t   iter_cnt;
  reg_word_t   first_size;
  reg_word_t   next_size;
  batch_mask_t batch_mask;

  // Results covered by one iteration when left results are still owed
  function automatic reg_word_t iter_size(input reg_word_t left);
    if (left > reg_word_t'(`CCU_RSLT_CHANNELS)) begin
      return reg_word_t'(`CCU_RSLT_CHANNELS);
    end
    return left;
  endfunction

  assign first_size = iter_size(ctrl.rslt_size);
  assign next_size  = iter_size(remaining);

  always_comb begin
    for (int i = 0; i < `CCU_RSLT_CHANNELS; i++) begin
      use_channels[i] = reg_word_t'(i) < cur_size;
    end
    for (int i = 0; i < `CCU_BATCH_SIZE; i++) begin
      batch_mask[i] = btch_count_t'(i) < ctrl.btch_size;
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst || iter.clear) begin
      remaining <= '0;
      cur_size  <= '0;
      exported  <= '0;
      iter_cnt  <= '0;
      use_batch <= '0;
    end else if (iter.load) begin
      remaining <= ctrl.rslt_size - first_size;
      cur_size  <= first_size;
      exported  <= '0;
      iter_cnt  <= '0;
      use_batch <= batch_mask;
    end else if (iter.advance) begin
      // Current iteration is finished, move on to the next one
      exported  <= exported + cur_size;
      remaining <= remaining - next_size;
      cur_size  <= next_size;
      iter_cnt  <= iter_cnt + 1'b1;
    end
  end

  // The iteration in flight is the last once nothing else is owed
  assign iter.last             = (remaining == '0);
  assign ctrl.results_exported = exported;
  assign ctrl.iter_count       = iter_cnt;

endmodule

// ==== rtl/ccu_sequencer.sv ====
`include "ccu_cfg.svh"

module ccu_sequencer (
  input  logic                       fsm_clk,
  input  logic                       fsm_rst,
  input  logic [`CCU_NUM_PERIPH-1:0] peripheral_error,
  input  logic                       rslt_tlast,
  ccu_ctrl_if.seq                    ctrl,
  ccu_iter_if.seq                    iter,
  output logic                       operation_start,
  output logic                       iteration_start,
  output ccu_pkg::data_size_t        data_size,
  output ccu_pkg::grid_size_t        grid_size,
  output ccu_pkg::scle_size_t        scle_size,
  output ccu_pkg::pckt_size_t        pckt_size,
  output logic                       operation_busy,
  output logic                       operation_complete,
  output logic                       operation_error,
  output logic                       locked,
  output logic                       pl2ps_intr
);
  import ccu_pkg::*;

  ccu_state_t state;
  ccu_state_t state_next;
  logic       soft_pend;
  logic       soft_due;
  logic       tlast_oper;
  logic       halt_cmd;
  logic       done_lock;
  logic       done_lock_next;

  assign tlast_oper = rslt_tlast && (state == st_oper);
  // Soft interrupt only bites at an iteration boundary
  assign soft_due   = tlast_oper && (soft_pend || ctrl.soft_cmd);
  assign halt_cmd   = ctrl.abort_cmd || ctrl.error_cmd;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (ctrl.start_req && !done_lock) begin
          state_next = ctrl.params_valid ? st_start : st_fault;
        end
      end
      st_start: state_next = st_oper;
      st_oper: begin
        if (tlast_oper && iter.last) begin
          state_next = st_done;
        end else if (soft_due) begin
          state_next = st_halt;
        end
      end
      st_done:  state_next = st_idle;
      st_halt:  state_next = st_idle;
      st_fault: state_next = st_fault;
      default:  state_next = st_idle;
    endcase
    if (|peripheral_error) state_next = st_fault;
    // Host commands override everything else
    if (halt_cmd) state_next = st_halt;
  end

  // Completed run stays locked until the host clears done
  always_comb begin
    done_lock_next = done_lock;
    if (state_next == st_done) begin
      done_lock_next = 1'b1;
    end else if (state != st_done && !ctrl.done_flag) begin
      done_lock_next = 1'b0;
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      state              <= st_idle;
      soft_pend          <= 1'b0;
      done_lock          <= 1'b0;
      operation_start    <= 1'b0;
      iteration_start    <= 1'b0;
      operation_busy     <= 1'b0;
      operation_complete <= 1'b0;
      operation_error    <= 1'b0;
      locked             <= 1'b0;
      pl2ps_intr         <= 1'b0;
      data_size          <= '0;
      grid_size          <= '0;
      scle_size          <= '0;
      pckt_size          <= '0;
    end else begin
      state              <= state_next;
      done_lock          <= done_lock_next;
      operation_start    <= (state_next == st_oper) && ((state == st_start) || tlast_oper);
      iteration_start    <= (state_next == st_oper);
      operation_busy     <= (state_next == st_start) || (state_next == st_oper);
      operation_complete <= (state_next == st_done);
      operation_error    <= (state_next == st_fault) ||
                            ((state_next == st_halt) && ctrl.error_cmd);
      locked             <= (state_next == st_fault) || done_lock_next;
      pl2ps_intr         <= ((state_next != state) &&
                             (state_next inside {st_start, st_done, st_fault})) ||
                            ((state_next == st_oper) && tlast_oper);
      if (state_next == st_start) begin
        data_size <= ctrl.data_size;
        grid_size <= ctrl.grid_size;
        scle_size <= ctrl.scle_size;
        pckt_size <= ctrl.pckt_size;
      end
      if ((state_next == st_start) || (state_next == st_oper)) begin
        if (tlast_oper) begin
          soft_pend <= 1'b0;
        end else if (ctrl.soft_cmd) begin
          soft_pend <= 1'b1;
        end
      end else begin
        soft_pend <= 1'b0;
      end
    end
  end

  assign ctrl.clear_start = (state == st_start) || (state == st_fault);
  assign ctrl.set_done    = (state_next == st_done) ||
                            ((state_next == st_halt) && ctrl.error_cmd);
  assign ctrl.busy        = operation_busy;
  assign ctrl.error       = operation_error;
  assign ctrl.locked      = locked;

  assign iter.load    = (state_next == st_start);
  assign iter.advance = tlast_oper;
  assign iter.clear   = (state_next == st_fault);

endmodule

// ==== rtl/central_control_unit.sv ====
`include "ccu_cfg.svh"

module central_control_unit (
  input  logic                       fsm_clk,
  input  logic                       fsm_rst,
  // Host register port
  input  logic                       reg_wr,
  input  logic                       reg_rd,
  input  ccu_pkg::reg_addr_t         reg_addr,
  input  ccu_pkg::reg_word_t         reg_wdata,
  output ccu_pkg::reg_word_t         reg_rdata,
  // Peripherals
  input  logic [`CCU_NUM_PERIPH-1:0] peripheral_error,
  input  logic                       rslt_tlast,
  // Run control towards the layer
  output logic                       operation_start,
  output logic                       iteration_start,
  output ccu_pkg::data_size_t        data_size,
  output ccu_pkg::grid_size_t        grid_size,
  output ccu_pkg::scle_size_t        scle_size,
  output ccu_pkg::pckt_size_t        pckt_size,
  output ccu_pkg::chan_mask_t        use_channels,
  output ccu_pkg::batch_mask_t       use_batch,
  // Status
  output logic                       operation_busy,
  output logic                       operation_complete,
  output logic                       operation_error,
  output logic                       locked,
  output logic                       pl2ps_intr
);

  ccu_ctrl_if ctrl_bus ();
  ccu_iter_if iter_bus ();

  ccu_register_file u_regs (
    .fsm_clk   (fsm_clk),
    .fsm_rst   (fsm_rst),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .ctrl      (ctrl_bus.regs)
  );

  ccu_sequencer u_seq (
    .fsm_clk            (fsm_clk),
    .fsm_rst            (fsm_rst),
    .peripheral_error   (peripheral_error),
    .rslt_tlast         (rslt_tlast),
    .ctrl               (ctrl_bus.seq),
    .iter               (iter_bus.seq),
    .operation_start    (operation_start),
    .iteration_start    (iteration_start),
    .data_size          (data_size),
    .grid_size          (grid_size),
    .scle_size          (scle_size),
    .pckt_size          (pckt_size),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .locked             (locked),
    .pl2ps_intr         (pl2ps_intr)
  );

  ccu_result_tracker u_track (
    .fsm_clk      (fsm_clk),
    .fsm_rst      (fsm_rst),
    .ctrl         (ctrl_bus.track),
    .iter         (iter_bus.track),
    .use_channels (use_channels),
    .use_batch    (use_batch)
  );

endmodule

// ==== tb/ccu_assertions.sv ====
`include "ccu_cfg.svh"

module ccu_assertions (
  input logic                       fsm_clk,
  input logic                       fsm_rst,
  input logic                       reg_wr,
  input ccu_pkg::reg_addr_t         reg_addr,
  input ccu_pkg::reg_word_t         reg_wdata,
  input logic [`CCU_NUM_PERIPH-1:0] peripheral_error,
  input logic                       rslt_tlast,
  input logic                       operation_start,
  input logic                       iteration_start,
  input ccu_pkg::data_size_t        data_size,
  input ccu_pkg::grid_size_t        grid_size,
  input ccu_pkg::scle_size_t        scle_size,
  input ccu_pkg::pckt_size_t        pckt_size,
  input ccu_pkg::chan_mask_t        use_channels,
  input ccu_pkg::batch_mask_t       use_batch,
  input logic                       operation_busy,
  input logic                       operation_complete,
  input logic                       operation_error,
  input logic                       locked,
  input logic                       pl2ps_intr
);
  import ccu_pkg::*;

  int        fail_count = 0;
  reg_word_t exp_rslt;
  reg_word_t exp_data;
  reg_word_t exp_grid;
  reg_word_t exp_scle;
  reg_word_t exp_pckt;
  reg_word_t exp_btch;
  reg_word_t tlast_cnt;
  reg_word_t iters_exp;
  reg_word_t left;
  reg_word_t chan_exp;
  logic      soft_armed;
  logic      host_clear;
  logic      host_halt;

  function automatic reg_word_t low_ones(input reg_word_t n);
    reg_word_t mask;
    mask = '0;
    for (int i = 0; i < 32; i++) begin
      if (i < n) mask[i] = 1'b1;
    end
    return mask;
  endfunction

  // Host writes that may release a locked controller
  assign host_clear = reg_wr && (reg_addr == reg_addr_t'(`CCU_REG_CTRL)) && !reg_wdata[1];
  assign host_halt  = reg_wr && (reg_addr == reg_addr_t'(`CCU_REG_INTR)) && |reg_wdata[2:1];

  // Expected iteration count and size of the iteration in flight
  assign iters_exp = (exp_rslt + `CCU_RSLT_CHANNELS - 1) / `CCU_RSLT_CHANNELS;
  assign left      = (exp_rslt > tlast_cnt * `CCU_RSLT_CHANNELS) ?
                     exp_rslt - tlast_cnt * `CCU_RSLT_CHANNELS : '0;
  assign chan_exp  = (left > `CCU_RSLT_CHANNELS) ? `CCU_RSLT_CHANNELS : left;

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      exp_rslt   <= '0;
      exp_data   <= '0;
      exp_grid   <= '0;
      exp_scle   <= '0;
      exp_pckt   <= '0;
      exp_btch   <= '0;
      tlast_cnt  <= '0;
      soft_armed <= 1'b0;
    end else begin
      if (reg_wr && reg_addr == reg_addr_t'(`CCU_REG_RSLT)) exp_rslt <= reg_wdata;
      if (reg_wr && reg_addr == reg_addr_t'(`CCU_REG_DATA)) exp_data <= reg_wdata;
      if (reg_wr && reg_addr == reg_addr_t'(`CCU_REG_GRID)) exp_grid <= reg_wdata;
      if (reg_wr && reg_addr == reg_addr_t'(`CCU_REG_SCALE)) exp_scle <= reg_wdata;
      if (reg_wr && reg_addr == reg_addr_t'(`CCU_REG_PCKT)) exp_pckt <= reg_wdata;
      if (reg_wr && reg_addr == reg_addr_t'(`CCU_REG_BTCH)) exp_btch <= reg_wdata[7:0];
      // Start cycle is busy without iteration_start
      if (operation_busy && !iteration_start) begin
        tlast_cnt <= '0;
      end else if (iteration_start && rslt_tlast) begin
        tlast_cnt <= tlast_cnt + 1;
      end
      if (!operation_busy) begin
        soft_armed <= 1'b0;
      end else if (reg_wr && reg_addr == reg_addr_t'(`CCU_REG_INTR) && reg_wdata[0]) begin
        soft_armed <= 1'b1;
      end
    end
  end

  reset_clears: assert property (@(posedge fsm_clk) fsm_rst |=>
      !(operation_start || iteration_start || operation_busy || operation_complete ||
        operation_error || locked || pl2ps_intr) && use_channels == '0 && use_batch == '0)
    else begin
      $error("ERR %0t: control outputs not cleared by reset", $time);
      fail_count++;
    end

  start_is_valid: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      operation_busy && !iteration_start |-> exp_data != '0 && pl2ps_intr)
    else begin
      $error("ERR %0t: run started without valid data size or interrupt", $time);
      fail_count++;
    end

  // Sizes on the outputs are the ones the host wrote before the start
  sizes_latched: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      operation_busy |-> data_size == data_size_t'(exp_data) &&
      grid_size == grid_size_t'(exp_grid) && scle_size == scle_size_t'(exp_scle) &&
      pckt_size == pckt_size_t'(exp_pckt))
    else begin
      $error("ERR %0t: latched sizes differ from the written parameters", $time);
      fail_count++;
    end

  channel_mask: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      iteration_start |-> use_channels == chan_mask_t'(low_ones(chan_exp)))
    else begin
      $error("ERR %0t: use_channels %b, expected %0d lanes", $time, use_channels, chan_exp);
      fail_count++;
    end

  batch_mask: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      operation_busy |-> use_batch == batch_mask_t'(low_ones(exp_btch)))
    else begin
      $error("ERR %0t: use_batch %b, expected %0d lanes", $time, use_batch, exp_btch);
      fail_count++;
    end

  complete_count: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      operation_complete |-> locked && tlast_cnt == iters_exp)
    else begin
      $error("ERR %0t: completion after %0d tlast, expected %0d", $time, tlast_cnt, iters_exp);
      fail_count++;
    end

  lock_release: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      $fell(locked) |-> $past(host_clear, 2) || $past(host_halt))
    else begin
      $error("ERR %0t: locked dropped without a done clear or host command", $time);
      fail_count++;
    end

  periph_fault: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      (|peripheral_error) && !host_halt |=> operation_error && locked && !operation_busy)
    else begin
      $error("ERR %0t: peripheral error did not lock the controller", $time);
      fail_count++;
    end

  // First iteration opens right after the start cycle
  start_pulse: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      operation_busy && !iteration_start |=> operation_start && iteration_start)
    else begin
      $error("ERR %0t: no operation_start after the start cycle", $time);
      fail_count++;
    end

  // Later pulses only follow a tlast that neither ends nor stops the run
  start_cause: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      operation_start |-> $past(operation_busy && !iteration_start) ||
      $past(iteration_start && rslt_tlast && !soft_armed && (tlast_cnt + 1 < iters_exp)))
    else begin
      $error("ERR %0t: operation_start without a start or a continuing tlast", $time);
      fail_count++;
    end

  soft_stop: assert property (@(posedge fsm_clk) disable iff (fsm_rst)
      iteration_start && rslt_tlast && soft_armed && (tlast_cnt + 1 < iters_exp) |=>
      !operation_busy && !operation_complete)
    else begin
      $error("ERR %0t: soft interrupt did not end the run at tlast", $time);
      fail_count++;
    end

endmodule

bind central_control_unit ccu_assertions checks (.*);

// ==== tb/tb_central_control_unit.sv ====
`include "ccu_cfg.svh"

module tb_central_control_unit;
  import ccu_pkg::*;

  localparam int lv_busy     = 0;
  localparam int lv_iter     = 1;
  localparam int lv_complete = 2;
  localparam int lv_error    = 3;
  localparam int lv_locked   = 4;

  logic                       fsm_clk;
  logic                       fsm_rst;
  logic                       reg_wr;
  logic                       reg_rd;
  reg_addr_t                  reg_addr;
  reg_word_t                  reg_wdata;
  reg_word_t                  reg_rdata;
  logic [`CCU_NUM_PERIPH-1:0] peripheral_error;
  logic                       rslt_tlast;
  logic                       operation_start;
  logic                       iteration_start;
  data_size_t                 data_size;
  grid_size_t                 grid_size;
  scle_size_t                 scle_size;
  pckt_size_t                 pckt_size;
  chan_mask_t                 use_channels;
  batch_mask_t                use_batch;
  logic                       operation_busy;
  logic                       operation_complete;
  logic                       operation_error;
  logic                       locked;
  logic                       pl2ps_intr;
  int                         seed;
  int                         err_count;
  int                         timeout_count;
  int                         assert_count;
  int                         n_iter;
  reg_word_t                  rslt_size;

  central_control_unit dut (.*);

  initial begin
    fsm_clk = 1'b0;
    forever #5 fsm_clk = ~fsm_clk;
  end

  task automatic write_reg(input int addr, input reg_word_t data);
    @(negedge fsm_clk);
    reg_wr    = 1'b1;
    reg_addr  = reg_addr_t'(addr);
    reg_wdata = data;
    @(negedge fsm_clk);
    reg_wr = 1'b0;
  endtask

  // Read data is valid one cycle after the strobe
  task automatic check_reg(input int addr, input reg_word_t exp, input string what);
    @(negedge fsm_clk);
    reg_rd   = 1'b1;
    reg_addr = reg_addr_t'(addr);
    @(negedge fsm_clk);
    reg_rd = 1'b0;
    if (reg_rdata !== exp) begin
      err_count++;
      $display("ERR %0t: %s reads %0h, expected %0h", $time, what, reg_rdata, exp);
    end
  endtask

  task automatic pulse_tlast();
    @(negedge fsm_clk);
    rslt_tlast = 1'b1;
    @(negedge fsm_clk);
    rslt_tlast = 1'b0;
  endtask

  function automatic logic level_of(input int sel);
    case (sel)
      lv_busy:     return operation_busy;
      lv_iter:     return iteration_start;
      lv_complete: return operation_complete;
      lv_error:    return operation_error;
      default:     return locked;
    endcase
  endfunction

  task automatic wait_level(input int sel, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (level_of(sel) !== level && cycles < 200) begin
      @(negedge fsm_clk);
      cycles++;
    end
    if (level_of(sel) !== level) begin
      timeout_count++;
      $display("Timed out after 200 cycles waiting for %s", what);
    end
  endtask

  initial begin
    fsm_rst          = 1'b1;
    reg_wr           = 1'b0;
    reg_rd           = 1'b0;
    reg_addr         = '0;
    reg_wdata        = '0;
    peripheral_error = '0;
    rslt_tlast       = 1'b0;
    seed             = 96;
    err_count        = 0;
    timeout_count    = 0;
    rslt_size        = reg_word_t'($unsigned($random(seed)) % 12 + 1);
    n_iter           = (rslt_size + `CCU_RSLT_CHANNELS - 1) / `CCU_RSLT_CHANNELS;
    repeat (16) @(posedge fsm_clk);
    @(negedge fsm_clk);
    fsm_rst = 1'b0;

    // Idle after reset, then parameter read-back
    check_reg(`CCU_REG_STATUS, 32'h01, "status after reset");
    write_reg(`CCU_REG_DATA, 100);
    write_reg(`CCU_REG_GRID, 64);
    write_reg(`CCU_REG_SCALE, 32);
    write_reg(`CCU_REG_PCKT, 256);
    write_reg(`CCU_REG_BTCH, 3);
    write_reg(`CCU_REG_LOADED, 32'hf);
    write_reg(`CCU_REG_RSLT, rslt_size);
    check_reg(`CCU_REG_DATA, 100, "data size");
    check_reg(`CCU_REG_GRID, 64, "grid size");
    check_reg(`CCU_REG_SCALE, 32, "scale size");
    check_reg(`CCU_REG_PCKT, 256, "packet size");
    check_reg(`CCU_REG_BTCH, 3, "batch size");
    check_reg(`CCU_REG_LOADED, 32'hf, "loaded flags");
    check_reg(`CCU_REG_RSLT, rslt_size, "result size");
    check_reg(`CCU_REG_STATUS, 32'h11, "status with valid parameters");

    // Full run over ceil(result size / channels) iterations
    write_reg(`CCU_REG_CTRL, 32'h1);
    for (int i = 0; i < n_iter; i++) begin
      wait_level(lv_iter, 1'b1, "iteration_start");
      pulse_tlast();
    end
    wait_level(lv_complete, 1'b1, "operation_complete");
    check_reg(`CCU_REG_EXPORTED, rslt_size, "results exported");
    check_reg(`CCU_REG_STATUS, 32'h18, "status while locked after done");
    write_reg(`CCU_REG_CTRL, 32'h0);
    wait_level(lv_locked, 1'b0, "locked release after done clear");
    check_reg(`CCU_REG_STATUS, 32'h11, "status after done clear");

    // Invalid start locks in fault until abort
    write_reg(`CCU_REG_DATA, 0);
    write_reg(`CCU_REG_CTRL, 32'h1);
    wait_level(lv_error, 1'b1, "operation_error on invalid start");
    check_reg(`CCU_REG_STATUS, 32'h0c, "status in fault");
    write_reg(`CCU_REG_INTR, 32'h2);
    wait_level(lv_locked, 1'b0, "locked release after abort");
    check_reg(`CCU_REG_STATUS, 32'h01, "status after abort");
    write_reg(`CCU_REG_DATA, 100);

    // Peripheral error in the middle of a run
    write_reg(`CCU_REG_CTRL, 32'h1);
    wait_level(lv_iter, 1'b1, "iteration_start before peripheral error");
    peripheral_error = 4'b0100;
    @(negedge fsm_clk);
    peripheral_error = '0;
    wait_level(lv_error, 1'b1, "operation_error on peripheral error");
    check_reg(`CCU_REG_STATUS, 32'h1c, "status after peripheral error");
    write_reg(`CCU_REG_INTR, 32'h2);
    wait_level(lv_locked, 1'b0, "locked release after abort");

    // Soft interrupt stops a three-iteration run after the second tlast
    write_reg(`CCU_REG_RSLT, 12);
    write_reg(`CCU_REG_BTCH, 2);
    write_reg(`CCU_REG_CTRL, 32'h1);
    wait_level(lv_iter, 1'b1, "iteration_start in soft run");
    pulse_tlast();
    write_reg(`CCU_REG_INTR, 32'h1);
    pulse_tlast();
    wait_level(lv_busy, 1'b0, "end of run after soft interrupt");
    check_reg(`CCU_REG_ITER, 2, "iteration count");
    check_reg(`CCU_REG_STATUS, 32'h11, "status after soft interrupt");

    repeat (4) @(negedge fsm_clk);
    assert_count = dut.checks.fail_count;
    $display("Summary: %0d read errors, %0d timeouts, %0d assertion failures",
             err_count, timeout_count, assert_count);
    if (err_count == 0 && timeout_count == 0 && assert_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/ccu_pkg.sv
rtl/ccu_ctrl_if.sv
rtl/ccu_register_file.sv
rtl/ccu_result_tracker.sv
rtl/ccu_sequencer.sv
rtl/central_control_unit.sv
tb/ccu_assertions.sv
tb/tb_central_control_unit.sv
